// ==== include/lcd_defs.svh ====
`ifndef LCD_DEFS_SVH
`define LCD_DEFS_SVH

// horizontal geometry, in pixel slots
`define LCD_H_ACTIVE 400
`define LCD_H_TOTAL 507 // includes blanking
`define LCD_HSYNC_X 400 // hsync column

// vertical geometry, in lines
`define LCD_V_ACTIVE 96
`define LCD_V_TOTAL 112
`define LCD_VSYNC_Y 95 // vsync line

// clk cycles per pixel slot
`define LCD_PIX_DIV 16

// pixel buffer depth, power of two
`define LCD_FIFO_DEPTH 8

`endif

// ==== rtl/lcd_pkg.sv ====
package lcd_pkg;

    // one color channel of the 6-bit panel
    typedef logic [5:0] chan_t;

    // 18-bit rgb pixel, red in the top bits
    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } pixel_t;

    // raster positions
    typedef logic [8:0] xcoord_t; // up to 511 columns
    typedef logic [6:0] ycoord_t; // up to 127 lines

    localparam pixel_t PIXEL_BLACK = '0;

endpackage

// ==== rtl/pattern_gen.sv ====
`include "lcd_defs.svh"

module pattern_gen (
    input  logic             clk,
    input  logic             rst,
    input  lcd_pkg::xcoord_t rect_x0_i,
    input  lcd_pkg::xcoord_t rect_x1_i,
    input  lcd_pkg::ycoord_t rect_y0_i,
    input  lcd_pkg::ycoord_t rect_y1_i,
    input  lcd_pkg::pixel_t  rect_color_i,
    input  logic             full_i,
    output logic             push_o,
    output lcd_pkg::pixel_t  pixel_o
);
    import lcd_pkg::*;

    localparam xcoord_t X_LAST = xcoord_t'(`LCD_H_ACTIVE - 1);
    localparam ycoord_t Y_LAST = ycoord_t'(`LCD_V_ACTIVE - 1);

    // raster position over the active area only
    xcoord_t x_q;
    ycoord_t y_q;

    // rectangle held for the whole frame
    xcoord_t x0_q;
    xcoord_t x1_q;
    ycoord_t y0_q;
    ycoord_t y1_q;
    pixel_t  color_q;

    logic load_q; // frame start, take new rectangle
    logic in_rect;

    always_ff @(posedge clk) begin
        if (rst) begin
            x_q    <= '0;
            y_q    <= '0;
            load_q <= 1'b1;
        end else if (load_q) begin
            load_q <= 1'b0; // no push on the latch cycle
        end else if (!full_i) begin
            if (x_q == X_LAST) begin
                x_q <= '0;
                if (y_q == Y_LAST) begin
                    y_q    <= '0;
                    load_q <= 1'b1;
                end else begin
                    y_q <= y_q + 1'b1;
                end
            end else begin
                x_q <= x_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_q) begin
            x0_q    <= rect_x0_i;
            x1_q    <= rect_x1_i;
            y0_q    <= rect_y0_i;
            y1_q    <= rect_y1_i;
            color_q <= rect_color_i;
        end
    end

    // open on the low side, closed on the high side
    assign in_rect = (x0_q < x_q) && (x_q <= x1_q) && (y0_q < y_q) && (y_q <= y1_q);

    assign push_o  = !load_q && !full_i;
    assign pixel_o = in_rect ? color_q : PIXEL_BLACK;

endmodule

// ==== rtl/pixel_fifo.sv ====
`include "lcd_defs.svh"

module pixel_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     full_o,
    output logic     not_empty_o
);

    localparam int DEPTH = `LCD_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    if ((1 << AW) != DEPTH) begin : g_depth_check
        $error("pixel_fifo: depth %0d is not a power of two", DEPTH);
    end

    payload_t mem [DEPTH];

    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q; // one extra bit to hold DEPTH
    logic          wr_en;
    logic          rd_en;

    assign wr_en = push_i && !full_o;
    assign rd_en = pop_i && not_empty_o;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // wraps, depth is 2**AW
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign data_o      = mem[rd_ptr_q];
    assign full_o      = (count_q == (AW + 1)'(DEPTH));
    assign not_empty_o = (count_q != '0);

    // the producer must respect full
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        push_i |-> !full_o
    ) else $error("pixel_fifo: push while full");

    // the consumer pops on its own schedule, buffer must never run dry
    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        pop_i |-> not_empty_o
    ) else $error("pixel_fifo: pop while empty");

endmodule

// ==== rtl/lcd_timing.sv ====
`include "lcd_defs.svh"

module lcd_timing (
    input  logic            clk,
    input  logic            rst,
    input  lcd_pkg::pixel_t pixel_i,
    input  logic            pixel_ready_i,
    output logic            pop_o,
    output lcd_pkg::chan_t  lcd_r_o,
    output lcd_pkg::chan_t  lcd_g_o,
    output lcd_pkg::chan_t  lcd_b_o,
    output logic            lcd_hsync_o,
    output logic            lcd_vsync_o,
    output logic            lcd_nclk_o,
    output logic            lcd_de_o
);
    import lcd_pkg::*;

    localparam int PH_W = $clog2(`LCD_PIX_DIV);

    // phase positions inside one pixel slot
    localparam logic [PH_W-1:0] PH_LAST = PH_W'(`LCD_PIX_DIV - 1);
    localparam logic [PH_W-1:0] PH_HALF = PH_W'(`LCD_PIX_DIV / 2);
    localparam logic [PH_W-1:0] PH_X    = PH_W'(`LCD_PIX_DIV - 4); // column step
    localparam logic [PH_W-1:0] PH_Y    = PH_W'(`LCD_PIX_DIV - 3); // line step
    localparam logic [PH_W-1:0] PH_OUT  = PH_W'(`LCD_PIX_DIV - 2); // output update

    localparam xcoord_t X_LAST   = xcoord_t'(`LCD_H_TOTAL - 1);
    localparam ycoord_t Y_LAST   = ycoord_t'(`LCD_V_TOTAL - 1);
    localparam xcoord_t X_ACTIVE = xcoord_t'(`LCD_H_ACTIVE);
    localparam ycoord_t Y_ACTIVE = ycoord_t'(`LCD_V_ACTIVE);
    localparam xcoord_t X_HSYNC  = xcoord_t'(`LCD_HSYNC_X);
    localparam ycoord_t Y_VSYNC  = ycoord_t'(`LCD_VSYNC_Y);

    logic [PH_W-1:0] phase_q;
    logic [PH_W-1:0] phase_nxt;

    // strobes, each high for the one cycle of its phase
    logic step_x_q;
    logic step_y_q;
    logic step_out_q;

    logic    nclk_q;
    xcoord_t x_q;
    ycoord_t y_q;
    logic    active;

    pixel_t rgb_q;
    logic   de_q;
    logic   hsync_q;
    logic   vsync_q;

    assign phase_nxt = (phase_q == PH_LAST) ? '0 : phase_q + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q    <= '0;
            step_x_q   <= 1'b0;
            step_y_q   <= 1'b0;
            step_out_q <= 1'b0;
            nclk_q     <= 1'b0;
        end else begin
            phase_q    <= phase_nxt;
            step_x_q   <= (phase_nxt == PH_X);
            step_y_q   <= (phase_nxt == PH_Y);
            step_out_q <= (phase_nxt == PH_OUT);
            nclk_q     <= (phase_nxt < PH_HALF); // high in first half of slot
        end
    end

    // frame counters, start in blanking
    always_ff @(posedge clk) begin
        if (rst) begin
            x_q <= X_HSYNC;
            y_q <= Y_ACTIVE;
        end else begin
            if (step_x_q) begin
                x_q <= (x_q == X_LAST) ? '0 : x_q + 1'b1;
            end
            if (step_y_q && x_q == '0) begin
                y_q <= (y_q == Y_LAST) ? '0 : y_q + 1'b1;
            end
        end
    end

    assign active = (x_q < X_ACTIVE) && (y_q < Y_ACTIVE);

    // head is consumed on the same edge that registers it
    assign pop_o = step_out_q && active;

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_q   <= PIXEL_BLACK;
            de_q    <= 1'b0;
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
        end else if (step_out_q) begin
            rgb_q   <= active ? pixel_i : PIXEL_BLACK;
            de_q    <= active;
            hsync_q <= (x_q == X_HSYNC);
            vsync_q <= (y_q == Y_VSYNC);
        end
    end

    assign lcd_r_o     = rgb_q.r;
    assign lcd_g_o     = rgb_q.g;
    assign lcd_b_o     = rgb_q.b;
    assign lcd_de_o    = de_q;
    assign lcd_hsync_o = hsync_q;
    assign lcd_vsync_o = vsync_q;
    assign lcd_nclk_o  = nclk_q;

    // producer has to stay ahead of the panel
    a_pixel_ready: assert property (
        @(posedge clk) disable iff (rst)
        pop_o |-> pixel_ready_i
    ) else $error("lcd_timing: pop with no pixel buffered");

endmodule

// ==== rtl/lcd_top.sv ====
module lcd_top (
    input  logic             clk,
    input  logic             rst,
    input  lcd_pkg::xcoord_t rect_x0_i,
    input  lcd_pkg::xcoord_t rect_x1_i,
    input  lcd_pkg::ycoord_t rect_y0_i,
    input  lcd_pkg::ycoord_t rect_y1_i,
    input  lcd_pkg::pixel_t  rect_color_i,
    output lcd_pkg::chan_t   lcd_r_o,
    output lcd_pkg::chan_t   lcd_g_o,
    output lcd_pkg::chan_t   lcd_b_o,
    output logic             lcd_hsync_o,
    output logic             lcd_vsync_o,
    output logic             lcd_nclk_o,
    output logic             lcd_de_o
);
    import lcd_pkg::*;

    logic   fifo_push;
    logic   fifo_pop;
    logic   fifo_full;
    logic   fifo_not_empty;
    pixel_t gen_pixel;
    pixel_t head_pixel;

    pattern_gen u_pattern_gen (
        .clk          (clk),
        .rst          (rst),
        .rect_x0_i    (rect_x0_i),
        .rect_x1_i    (rect_x1_i),
        .rect_y0_i    (rect_y0_i),
        .rect_y1_i    (rect_y1_i),
        .rect_color_i (rect_color_i),
        .full_i       (fifo_full),
        .push_o       (fifo_push),
        .pixel_o      (gen_pixel)
    );

    pixel_fifo #(
        .payload_t (pixel_t)
    ) u_pixel_fifo (
        .clk         (clk),
        .rst         (rst),
        .push_i      (fifo_push),
        .data_i      (gen_pixel),
        .pop_i       (fifo_pop),
        .data_o      (head_pixel),
        .full_o      (fifo_full),
        .not_empty_o (fifo_not_empty)
    );

    lcd_timing u_lcd_timing (
        .clk           (clk),
        .rst           (rst),
        .pixel_i       (head_pixel),
        .pixel_ready_i (fifo_not_empty),
        .pop_o         (fifo_pop),
        .lcd_r_o       (lcd_r_o),
        .lcd_g_o       (lcd_g_o),
        .lcd_b_o       (lcd_b_o),
        .lcd_hsync_o   (lcd_hsync_o),
        .lcd_vsync_o   (lcd_vsync_o),
        .lcd_nclk_o    (lcd_nclk_o),
        .lcd_de_o      (lcd_de_o)
    );

endmodule

// ==== testbench/tb_lcd_top.sv ====
`include "lcd_defs.svh"

module tb_lcd_top;
    timeunit 1ns;
    timeprecision 100ps;

    import lcd_pkg::*;

    localparam int MAX_LINES    = 64;
    localparam int MAX_CFG      = 8;
    localparam int NUM_FRAMES   = 3;
    localparam int CHANGE_LINE  = 40;
    localparam int BLANK_LINES  = `LCD_V_TOTAL - `LCD_V_ACTIVE;
    localparam int FRAME_CYCLES = `LCD_H_TOTAL * `LCD_V_TOTAL * `LCD_PIX_DIV;
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;

    logic    clk;
    logic    rst;
    xcoord_t rect_x0;
    xcoord_t rect_x1;
    ycoord_t rect_y0;
    ycoord_t rect_y1;
    pixel_t  rect_color;
    chan_t   lcd_r;
    chan_t   lcd_g;
    chan_t   lcd_b;
    logic    lcd_hsync;
    logic    lcd_vsync;
    logic    lcd_nclk;
    logic    lcd_de;

    logic [71:0] stim_mem [MAX_LINES];

    // rectangle per frame, later frames inherit
    int     cfg_x0 [MAX_CFG];
    int     cfg_x1 [MAX_CFG];
    int     cfg_y0 [MAX_CFG];
    int     cfg_y1 [MAX_CFG];
    pixel_t cfg_color [MAX_CFG];
    logic   cfg_valid [MAX_CFG];

    int     num_samples;
    int     smp_frame [MAX_LINES];
    int     smp_x [MAX_LINES];
    int     smp_y [MAX_LINES];
    pixel_t smp_color [MAX_LINES];
    logic   smp_seen [MAX_LINES];

    // panel-side position tracking
    int     frame_idx;
    int     row;
    int     col;
    int     nclk_count;
    int     hsync_count;
    int     hsync_total;
    int     de_lines;
    logic   seen_hsync;
    logic   seen_vsync;
    logic   first_de_seen;
    logic   nclk_prev;
    logic   hsync_prev;
    logic   vsync_prev;
    pixel_t got;

    int   pixels_checked;
    int   mismatches;
    int   failures;
    logic timed_out;

    lcd_top dut (
        .clk          (clk),
        .rst          (rst),
        .rect_x0_i    (rect_x0),
        .rect_x1_i    (rect_x1),
        .rect_y0_i    (rect_y0),
        .rect_y1_i    (rect_y1),
        .rect_color_i (rect_color),
        .lcd_r_o      (lcd_r),
        .lcd_g_o      (lcd_g),
        .lcd_b_o      (lcd_b),
        .lcd_hsync_o  (lcd_hsync),
        .lcd_vsync_o  (lcd_vsync),
        .lcd_nclk_o   (lcd_nclk),
        .lcd_de_o     (lcd_de)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic load_stimulus();
        logic [71:0] w;
        int          kind;
        int          f;
        for (int i = 0; i < MAX_LINES; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("testbench/lcd_stimulus.txt", stim_mem);
        num_samples = 0;
        for (int i = 0; i < MAX_CFG; i++) begin
            cfg_valid[i] = 1'b0;
        end
        for (int i = 0; i < MAX_LINES; i++) begin
            w    = stim_mem[i];
            kind = int'(w[71:68]);
            f    = int'(w[67:64]);
            if (kind == 1 && f < MAX_CFG) begin
                cfg_x0[f]    = int'(w[63:52]);
                cfg_x1[f]    = int'(w[51:40]);
                cfg_y0[f]    = int'(w[39:32]);
                cfg_y1[f]    = int'(w[31:24]);
                cfg_color[f] = pixel_t'(w[17:0]);
                cfg_valid[f] = 1'b1;
            end else if (kind == 2) begin
                smp_frame[num_samples] = f;
                smp_x[num_samples]     = int'(w[63:52]);
                smp_y[num_samples]     = int'(w[39:32]);
                smp_color[num_samples] = pixel_t'(w[17:0]);
                smp_seen[num_samples]  = 1'b0;
                num_samples++;
            end
        end
        for (int i = 1; i < MAX_CFG; i++) begin
            if (!cfg_valid[i]) begin
                cfg_x0[i]    = cfg_x0[i-1];
                cfg_x1[i]    = cfg_x1[i-1];
                cfg_y0[i]    = cfg_y0[i-1];
                cfg_y1[i]    = cfg_y1[i-1];
                cfg_color[i] = cfg_color[i-1];
            end
        end
    endtask

    task automatic drive_config(input int f);
        rect_x0    = xcoord_t'(cfg_x0[f]);
        rect_x1    = xcoord_t'(cfg_x1[f]);
        rect_y0    = ycoord_t'(cfg_y0[f]);
        rect_y1    = ycoord_t'(cfg_y1[f]);
        rect_color = cfg_color[f];
    endtask

    // open low bound, closed high bound
    function automatic pixel_t rect_rule_color(input int f, input int x, input int y);
        int k;
        k = (f < MAX_CFG) ? f : MAX_CFG - 1;
        if (cfg_x0[k] < x && x <= cfg_x1[k] && cfg_y0[k] < y && y <= cfg_y1[k]) begin
            return cfg_color[k];
        end
        return '0;
    endfunction

    task automatic check_outputs_low(input string when);
        if (lcd_de || lcd_hsync || lcd_vsync || lcd_r != '0 || lcd_g != '0 || lcd_b != '0) begin
            $display("error at %0t: panel outputs not low %s", $time, when);
            mismatches++;
        end
    endtask

    task automatic check_pixel(input pixel_t px);
        pixel_t want;
        want = rect_rule_color(frame_idx, col, row);
        pixels_checked++;
        if (px != want) begin
            $display("error at %0t: frame %0d pixel (%0d,%0d) is %h, expected %h",
                     $time, frame_idx, col, row, px, want);
            mismatches++;
        end
        for (int i = 0; i < num_samples; i++) begin
            if (smp_frame[i] == frame_idx && smp_x[i] == col && smp_y[i] == row) begin
                smp_seen[i] = 1'b1;
                if (px != smp_color[i]) begin
                    $display("error at %0t: frame %0d sample (%0d,%0d) is %h, file says %h",
                             $time, frame_idx, col, row, px, smp_color[i]);
                    mismatches++;
                end
            end
        end
    endtask

    // sample the panel at nclk rising edges, away from clk
    always @(negedge clk) begin
        if (rst) begin
            check_outputs_low("during reset");
        end else if (lcd_nclk && !nclk_prev) begin
            nclk_count++;
            got = {lcd_r, lcd_g, lcd_b};
            if (lcd_de) begin
                if (!first_de_seen) begin
                    first_de_seen = 1'b1;
                    // first line after reset starts past the hsync column
                    if (hsync_total != BLANK_LINES - 1) begin
                        $display("error at %0t: first de after %0d hsync pulses, expected %0d",
                                 $time, hsync_total, BLANK_LINES - 1);
                        mismatches++;
                    end
                end
                check_pixel(got);
                col++;
            end else if (got != '0) begin
                $display("error at %0t: rgb %h while de is low", $time, got);
                mismatches++;
            end
            if (lcd_hsync && !hsync_prev) begin
                if (seen_hsync && nclk_count != `LCD_H_TOTAL) begin
                    $display("error at %0t: %0d nclk edges in a line, expected %0d",
                             $time, nclk_count, `LCD_H_TOTAL);
                    mismatches++;
                end
                if (col != 0 && col != `LCD_H_ACTIVE) begin
                    $display("error at %0t: %0d de pixels in a line", $time, col);
                    mismatches++;
                end
                if (col != 0) begin
                    row++;
                    de_lines++;
                end
                hsync_count++;
                hsync_total++;
                nclk_count = 0;
                col        = 0;
                seen_hsync = 1'b1;
            end
            if (lcd_vsync && !vsync_prev) begin
                if (seen_vsync && (hsync_count != `LCD_V_TOTAL || de_lines != `LCD_V_ACTIVE)) begin
                    $display("error at %0t: frame had %0d lines and %0d de lines",
                             $time, hsync_count, de_lines);
                    mismatches++;
                end
                seen_vsync  = 1'b1;
                hsync_count = 0;
                de_lines    = 0;
            end
            if (!lcd_vsync && vsync_prev) begin
                frame_idx++; // end of the last active line
                row = 0;
            end
            hsync_prev = lcd_hsync;
            vsync_prev = lcd_vsync;
        end
        nclk_prev = lcd_nclk;
    end

    task automatic wait_for_line(input int f, input int line);
        int cycles;
        cycles = 0;
        while (!(frame_idx == f && row == line) && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!(frame_idx == f && row == line)) begin
            $display("timeout: line %0d of frame %0d never reached the panel", line, f);
            failures++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_frame(input int f);
        int cycles;
        cycles = 0;
        while (frame_idx < f && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (frame_idx < f) begin
            $display("timeout: frame %0d never finished on the panel", f - 1);
            failures++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        rst            = 1'b1;
        rect_x0        = '0;
        rect_x1        = '0;
        rect_y0        = '0;
        rect_y1        = '0;
        rect_color     = '0;
        frame_idx      = 0;
        row            = 0;
        col            = 0;
        nclk_count     = 0;
        hsync_count    = 0;
        hsync_total    = 0;
        de_lines       = 0;
        seen_hsync     = 1'b0;
        seen_vsync     = 1'b0;
        first_de_seen  = 1'b0;
        nclk_prev      = 1'b0;
        hsync_prev     = 1'b0;
        vsync_prev     = 1'b0;
        pixels_checked = 0;
        mismatches     = 0;
        failures       = 0;
        timed_out      = 1'b0;
        load_stimulus();
        drive_config(0);
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_outputs_low("right after reset");
        for (int f = 1; f < NUM_FRAMES; f++) begin
            if (!timed_out && cfg_valid[f]) begin
                wait_for_line(f - 1, CHANGE_LINE);
                @(posedge clk);
                #1 drive_config(f);
            end
        end
        if (!timed_out) begin
            wait_for_frame(NUM_FRAMES);
        end
        for (int i = 0; i < num_samples; i++) begin
            if (!smp_seen[i]) begin
                $display("sample (%0d,%0d) of frame %0d was never shown on the panel",
                         smp_x[i], smp_y[i], smp_frame[i]);
                failures++;
            end
        end
        $display("%0d pixels checked, %0d mismatches, %0d other failures",
                 pixels_checked, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== testbench/lcd_stimulus.txt ====
// kind_frame_xa_xb_ya_yb_color in hex, color is {r,g,b} with 6 bits each
// kind 1: rectangle x0=xa x1=xb y0=ya y1=yb for a frame; kind 2: sample at x=xa y=ya
1_0_032_096_0a_3c_03f000
1_1_0c8_18f_1e_5f_015abf
1_2_000_18f_50_5f_02aaaa
2_0_032_000_1e_00_000000
2_0_033_000_1e_00_03f000
2_0_096_000_3c_00_03f000
2_0_097_000_3c_00_000000
2_0_064_000_0a_00_000000
2_0_064_000_0b_00_03f000
2_0_064_000_3d_00_000000
2_0_12c_000_32_00_000000
2_1_12c_000_32_00_015abf
2_1_0c9_000_1f_00_015abf
2_1_0c8_000_1f_00_000000
2_1_18f_000_5f_00_015abf
2_1_064_000_1e_00_000000
2_1_00a_000_5a_00_000000
2_2_00a_000_5a_00_02aaaa
2_2_000_000_5a_00_000000
2_2_18f_000_51_00_02aaaa
2_2_18f_000_50_00_000000
2_2_12c_000_32_00_000000

// ==== sim.f ====
+incdir+include
rtl/lcd_pkg.sv
rtl/pattern_gen.sv
rtl/pixel_fifo.sv
rtl/lcd_timing.sv
rtl/lcd_top.sv
testbench/tb_lcd_top.sv

// ==== Makefile ====
all: run

obj_dir/Vtb_lcd_top: sim.f $(wildcard rtl/*.sv testbench/*.sv include/*.svh)
	verilator --binary --timing --assert -f sim.f --top-module tb_lcd_top

.PHONY: all run clean

run: obj_dir/Vtb_lcd_top
	out="$$(./obj_dir/Vtb_lcd_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
